// File: design/gat_settings.svh
// Size and width macros for the GAT output write-back stage
`ifndef GAT_SETTINGS_SVH
`define GAT_SETTINGS_SVH

// ====================
// Feature vector shape
// ====================

// Lanes per new-feature vector
`define GAT_NUM_FEATURE_OUT 4
`define GAT_FEATURE_WIDTH   32

// Signed WH lane and unsigned attention coefficient
`define GAT_WH_WIDTH        12
`define GAT_ALPHA_WIDTH     16

// ====================
// Run and storage size
// ====================

`define GAT_NUM_NODES       6
`define GAT_FIFO_DEPTH      4

// One BRAM word per lane per node
`define GAT_FEAT_DEPTH      (`GAT_NUM_NODES * `GAT_NUM_FEATURE_OUT)
`define GAT_FEAT_ADDR_WIDTH 5
`define GAT_LANE_WIDTH      2

`endif

// File: design/gat_pkg.sv
// Vector typedefs and aggregator state enum for the GAT output stage
`include "gat_settings.svh"

package gat_pkg;

  // One signed lane and a whole WH row, lane 0 in the low bits
  typedef logic signed [`GAT_WH_WIDTH-1:0]                      wh_t;
  typedef logic [`GAT_NUM_FEATURE_OUT*`GAT_WH_WIDTH-1:0]        wh_row_t;

  // Attention coefficient, unsigned
  typedef logic [`GAT_ALPHA_WIDTH-1:0]                          alpha_t;

  // New-feature word and vector, lane 0 in the low bits
  typedef logic [`GAT_FEATURE_WIDTH-1:0]                        feature_t;
  typedef logic [`GAT_NUM_FEATURE_OUT*`GAT_FEATURE_WIDTH-1:0]   feature_vec_t;

  typedef logic [`GAT_FEAT_ADDR_WIDTH-1:0]                      feat_addr_t;
  typedef logic [`GAT_LANE_WIDTH-1:0]                           lane_idx_t;

  // Input receiver FSM
  typedef enum logic [1:0] {
    agg_idle,
    agg_accumulate,
    agg_ack,
    agg_push
  } agg_state_t;

endpackage

// File: design/feature_aggregator.sv
// Four-phase input receiver with per-lane multiply-accumulate and FIFO push
`timescale 1ns/10ps
`include "gat_settings.svh"

module feature_aggregator (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_req,
  input  gat_pkg::alpha_t       in_alpha,
  input  gat_pkg::wh_row_t      in_wh_row,
  input  logic                  in_last,
  input  logic                  fifo_full,
  output logic                  in_ack,
  output logic                  fifo_push,
  output gat_pkg::feature_vec_t fifo_din
);

  gat_pkg::agg_state_t   state;

  gat_pkg::alpha_t       alpha_reg;
  gat_pkg::wh_row_t      wh_row_reg;
  logic                  last_reg;

  // One running sum per lane
  gat_pkg::feature_vec_t acc;
  gat_pkg::feature_vec_t acc_next;

  // ====================
  // Beat capture
  // ====================

  // Payload is stable while in_req is high
  always_ff @(posedge clk) begin
    if ((state == gat_pkg::agg_idle) && in_req) begin
      alpha_reg  <= in_alpha;
      wh_row_reg <= in_wh_row;
      last_reg   <= in_last;
    end
  end

  // ====================
  // Multiply-accumulate
  // ====================

  always_comb begin
    gat_pkg::wh_t      lane;
    gat_pkg::feature_t lane_ext;
    gat_pkg::feature_t alpha_ext;
    // Zero-extend the coefficient
    alpha_ext = gat_pkg::feature_t'(alpha_reg);
    acc_next  = acc;
    for (int i = 0; i < `GAT_NUM_FEATURE_OUT; i++) begin
      lane     = wh_row_reg[i*`GAT_WH_WIDTH +: `GAT_WH_WIDTH];
      // Sign-extend the lane, product wraps at 32 bits
      lane_ext = gat_pkg::feature_t'(lane);
      acc_next[i*`GAT_FEATURE_WIDTH +: `GAT_FEATURE_WIDTH] =
        acc[i*`GAT_FEATURE_WIDTH +: `GAT_FEATURE_WIDTH] + alpha_ext * lane_ext;
    end
  end

  // ====================
  // Receiver FSM
  // ====================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= gat_pkg::agg_idle;
      in_ack <= 1'b0;
      acc    <= '0;
    end else begin
      case (state)
        gat_pkg::agg_idle: begin
          if (in_req) begin
            state <= gat_pkg::agg_accumulate;
          end
        end
        gat_pkg::agg_accumulate: begin
          acc <= acc_next;
          if (last_reg) begin
            state <= gat_pkg::agg_push;
          end else begin
            in_ack <= 1'b1;
            state  <= gat_pkg::agg_ack;
          end
        end
        gat_pkg::agg_push: begin
          // Hold ack back while the FIFO is full
          if (!fifo_full) begin
            acc    <= '0;
            in_ack <= 1'b1;
            state  <= gat_pkg::agg_ack;
          end
        end
        gat_pkg::agg_ack: begin
          if (!in_req) begin
            in_ack <= 1'b0;
            state  <= gat_pkg::agg_idle;
          end
        end
        default: begin
          state <= gat_pkg::agg_idle;
        end
      endcase
    end
  end

  assign fifo_push = (state == gat_pkg::agg_push) && !fifo_full;
  assign fifo_din  = acc;

  // Ack only answers a pending request
  a_ack_needs_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(in_ack) |-> in_req
  );

endmodule

// File: design/feature_fifo.sv
// Synchronous FIFO of whole new-feature vectors
`timescale 1ns/10ps
`include "gat_settings.svh"

module feature_fifo (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  fifo_push,
  input  gat_pkg::feature_vec_t fifo_din,
  input  logic                  fifo_pop,
  output gat_pkg::feature_vec_t fifo_dout,
  output logic                  fifo_full,
  output logic                  fifo_empty
);

  gat_pkg::feature_vec_t                mem [`GAT_FIFO_DEPTH];

  logic [$clog2(`GAT_FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(`GAT_FIFO_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(`GAT_FIFO_DEPTH):0]     count;

  logic                                 do_push;
  logic                                 do_pop;

  assign do_push = fifo_push && !fifo_full;
  assign do_pop  = fifo_pop && !fifo_empty;

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= fifo_din;
    end
  end

  // ====================
  // Pointers and level
  // ====================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == ($clog2(`GAT_FIFO_DEPTH))'(`GAT_FIFO_DEPTH - 1)) ?
                  '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == ($clog2(`GAT_FIFO_DEPTH))'(`GAT_FIFO_DEPTH - 1)) ?
                  '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the level unchanged
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head is visible without read latency
  assign fifo_dout  = mem[rd_ptr];
  assign fifo_full  = (count == `GAT_FIFO_DEPTH);
  assign fifo_empty = (count == '0);

  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    fifo_push |-> !fifo_full
  );

  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    fifo_pop |-> !fifo_empty
  );

endmodule

// File: design/feature_controller.sv
// Vector pop, lane serializer, BRAM write addressing and run completion flag
`timescale 1ns/10ps
`include "gat_settings.svh"

module feature_controller (
  input  logic                  clk,
  input  logic                  rst_n,
  input  gat_pkg::feature_vec_t fifo_dout,
  input  logic                  fifo_empty,
  output logic                  fifo_pop,
  output logic                  bram_we,
  output gat_pkg::feat_addr_t   bram_waddr,
  output gat_pkg::feature_t     bram_wdata,
  output logic                  gat_ready
);

  gat_pkg::feature_vec_t vec_reg;
  gat_pkg::feature_vec_t vec_cur;
  gat_pkg::lane_idx_t    lane_cnt;
  gat_pkg::lane_idx_t    lane_sel;

  // ====================
  // Pop and lane select
  // ====================

  // New vector only once the previous one is fully written
  assign fifo_pop = (lane_cnt == '0) && !fifo_empty;
  assign bram_we  = fifo_pop || (lane_cnt != '0);

  // Lane 3 goes out straight from the FIFO head
  assign vec_cur  = fifo_pop ? fifo_dout : vec_reg;

  // Highest lane first
  assign lane_sel = gat_pkg::lane_idx_t'(`GAT_NUM_FEATURE_OUT - 1) - lane_cnt;

  assign bram_wdata = vec_cur[lane_sel*`GAT_FEATURE_WIDTH +: `GAT_FEATURE_WIDTH];

  always_ff @(posedge clk) begin
    if (fifo_pop) begin
      vec_reg <= fifo_dout;
    end
  end

  // ====================
  // Counters
  // ====================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_cnt   <= '0;
      bram_waddr <= '0;
    end else if (bram_we) begin
      if (lane_cnt == gat_pkg::lane_idx_t'(`GAT_NUM_FEATURE_OUT - 1)) begin
        lane_cnt <= '0;
      end else begin
        lane_cnt <= lane_cnt + 1'b1;
      end
      bram_waddr <= bram_waddr + 1'b1;
    end
  end

  // Sticky once the last word of the run is written
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gat_ready <= 1'b0;
    end else if (bram_we &&
                 (bram_waddr == gat_pkg::feat_addr_t'(`GAT_FEAT_DEPTH - 1))) begin
      gat_ready <= 1'b1;
    end
  end

  a_addr_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    bram_we |-> (bram_waddr <= gat_pkg::feat_addr_t'(`GAT_FEAT_DEPTH - 1))
  );

endmodule

// File: design/feature_bram.sv
// New-feature memory with one write port and one registered read port
`timescale 1ns/10ps
`include "gat_settings.svh"

module feature_bram (
  input  logic                clk,
  input  logic                bram_we,
  input  gat_pkg::feat_addr_t bram_waddr,
  input  gat_pkg::feature_t   bram_wdata,
  input  gat_pkg::feat_addr_t rd_addr,
  output gat_pkg::feature_t   rd_data
);

  gat_pkg::feature_t mem [`GAT_FEAT_DEPTH];

  // ====================
  // Write port
  // ====================

  always_ff @(posedge clk) begin
    if (bram_we) begin
      mem[bram_waddr] <= bram_wdata;
    end
  end

  // ====================
  // Read port
  // ====================

  // One cycle read latency
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// File: design/gat_output_top.sv
// Top level of the GAT output stage wiring aggregator, FIFO, controller and BRAM
`timescale 1ns/10ps
`include "gat_settings.svh"

module gat_output_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_req,
  input  gat_pkg::alpha_t     in_alpha,
  input  gat_pkg::wh_row_t    in_wh_row,
  input  logic                in_last,
  input  gat_pkg::feat_addr_t rd_addr,
  output logic                in_ack,
  output gat_pkg::feature_t   rd_data,
  output logic                gat_ready
);

  // Aggregator to FIFO
  logic                  fifo_push;
  gat_pkg::feature_vec_t fifo_din;
  logic                  fifo_full;

  // FIFO to controller
  logic                  fifo_pop;
  gat_pkg::feature_vec_t fifo_dout;
  logic                  fifo_empty;

  // Controller to BRAM
  logic                  bram_we;
  gat_pkg::feat_addr_t   bram_waddr;
  gat_pkg::feature_t     bram_wdata;

  feature_aggregator aggregator_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_req     (in_req),
    .in_alpha   (in_alpha),
    .in_wh_row  (in_wh_row),
    .in_last    (in_last),
    .fifo_full  (fifo_full),
    .in_ack     (in_ack),
    .fifo_push  (fifo_push),
    .fifo_din   (fifo_din)
  );

  feature_fifo fifo_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .fifo_push  (fifo_push),
    .fifo_din   (fifo_din),
    .fifo_pop   (fifo_pop),
    .fifo_dout  (fifo_dout),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty)
  );

  feature_controller controller_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .fifo_dout  (fifo_dout),
    .fifo_empty (fifo_empty),
    .fifo_pop   (fifo_pop),
    .bram_we    (bram_we),
    .bram_waddr (bram_waddr),
    .bram_wdata (bram_wdata),
    .gat_ready  (gat_ready)
  );

  feature_bram bram_i (
    .clk        (clk),
    .bram_we    (bram_we),
    .bram_waddr (bram_waddr),
    .bram_wdata (bram_wdata),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data)
  );

endmodule

// File: tb/tb_gat_output.sv
// Testbench for the GAT output stage with LFSR stimulus, reference model and directed tests
`timescale 1ns/10ps
`include "gat_settings.svh"

module tb_gat_output;

  // Beats sent over all tests, used for the timeout bound
  localparam int TOTAL_BEATS    = 9;
  localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 8 + `GAT_NUM_NODES * 4 + 200;

  logic                  clk;
  logic                  rst_n;
  logic                  in_req;
  gat_pkg::alpha_t       in_alpha;
  gat_pkg::wh_row_t      in_wh_row;
  logic                  in_last;
  gat_pkg::feat_addr_t   rd_addr;
  logic                  in_ack;
  gat_pkg::feature_t     rd_data;
  logic                  gat_ready;

  logic [31:0]           lfsr_state;
  int                    cycle_count;
  int                    err_count;

  // Expected BRAM contents and the node being accumulated
  logic [31:0]           model [`GAT_FEAT_DEPTH];
  int                    node_acc [`GAT_NUM_FEATURE_OUT];
  int                    node_count;

  gat_output_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_req    (in_req),
    .in_alpha  (in_alpha),
    .in_wh_row (in_wh_row),
    .in_last   (in_last),
    .rd_addr   (rd_addr),
    .in_ack    (in_ack),
    .rd_data   (rd_data),
    .gat_ready (gat_ready)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Checks failed");
      $fatal(1, "timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    end
  end

  // ====================
  // Random source
  // ====================

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // ====================
  // Reference model
  // ====================

  // alpha is unsigned, lanes are signed, sums wrap at 32 bits
  task automatic model_beat(input gat_pkg::alpha_t alpha, input gat_pkg::wh_row_t row);
    logic signed [`GAT_WH_WIDTH-1:0] lane;
    int                              lane_int;
    int                              alpha_int;
    alpha_int = int'({16'b0, alpha});
    for (int k = 0; k < `GAT_NUM_FEATURE_OUT; k++) begin
      lane     = row[k*`GAT_WH_WIDTH +: `GAT_WH_WIDTH];
      lane_int = lane;
      node_acc[k] = node_acc[k] + alpha_int * lane_int;
    end
  endtask

  // Highest lane lands at the lowest address of the node
  task automatic model_close_node();
    int base;
    base = node_count * `GAT_NUM_FEATURE_OUT;
    for (int k = 0; k < `GAT_NUM_FEATURE_OUT; k++) begin
      model[base + `GAT_NUM_FEATURE_OUT - 1 - k] = node_acc[k];
      node_acc[k] = 0;
    end
    node_count = node_count + 1;
  endtask

  // ====================
  // Driver and checks
  // ====================

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      err_count = err_count + 1;
      $display("mismatch in %s: expected %h, actual %h", name, expected, actual);
      $display("Checks failed");
      $fatal(1, "stopping at the first error");
    end
  endtask

  // Four-phase handshake for one beat
  task automatic send_beat(input gat_pkg::alpha_t alpha, input gat_pkg::wh_row_t row,
                           input logic last);
    @(posedge clk);
    in_req    <= 1'b1;
    in_alpha  <= alpha;
    in_wh_row <= row;
    in_last   <= last;
    do @(negedge clk); while (!in_ack);
    @(posedge clk);
    in_req <= 1'b0;
    do @(negedge clk); while (in_ack);
    model_beat(alpha, row);
    if (last) begin
      model_close_node();
    end
  endtask

  task automatic send_lfsr_node(input int beats);
    gat_pkg::alpha_t  alpha;
    gat_pkg::wh_row_t row;
    for (int b = 0; b < beats; b++) begin
      alpha = gat_pkg::alpha_t'(take_bits(`GAT_ALPHA_WIDTH));
      for (int k = 0; k < `GAT_NUM_FEATURE_OUT; k++) begin
        row[k*`GAT_WH_WIDTH +: `GAT_WH_WIDTH] = `GAT_WH_WIDTH'(take_bits(`GAT_WH_WIDTH));
      end
      send_beat(alpha, row, b == beats - 1);
    end
  endtask

  task automatic read_word(input int addr, output gat_pkg::feature_t data);
    @(posedge clk);
    rd_addr <= gat_pkg::feat_addr_t'(addr);
    @(posedge clk);
    @(negedge clk);
    data = rd_data;
  endtask

  task automatic check_range(input string name, input int first, input int last);
    gat_pkg::feature_t data;
    for (int a = first; a <= last; a++) begin
      read_word(a, data);
      check(name, model[a], data);
    end
  endtask

  // Controller writes 4 cycles per vector, so a full FIFO drains in this bound
  task automatic wait_drain();
    repeat (`GAT_FIFO_DEPTH * `GAT_NUM_FEATURE_OUT) @(posedge clk);
  endtask

  // ====================
  // Directed tests
  // ====================

  task automatic test_reset_state();
    repeat (5) begin
      @(negedge clk);
      check("reset_state in_ack", 32'h0, 32'(in_ack));
      check("reset_state gat_ready", 32'h0, 32'(gat_ready));
    end
  endtask

  task automatic test_single_neighbor();
    gat_pkg::wh_row_t row;
    // Lanes 3..0 are -2048, 100, -7, 5
    row = {12'h800, 12'd100, 12'hFF9, 12'd5};
    send_beat(16'd3, row, 1'b1);
    repeat (4) @(posedge clk);
    check_range("single_neighbor", 0, 3);
  endtask

  task automatic test_multi_neighbor();
    send_lfsr_node(3);
    wait_drain();
    check_range("multi_neighbor", 4, 7);
  endtask

  task automatic test_back_pressure();
    send_lfsr_node(1);
    send_lfsr_node(1);
    send_lfsr_node(1);
    wait_drain();
    check_range("back_pressure", 8, 19);
  endtask

  task automatic test_run_completion();
    @(negedge clk);
    check("run_completion early gat_ready", 32'h0, 32'(gat_ready));
    send_lfsr_node(2);
    // Bounded by the cycle timeout
    do @(negedge clk); while (!gat_ready);
    check_range("run_completion", 0, `GAT_FEAT_DEPTH - 1);
    // Flag stays set through the readback
    check("run_completion gat_ready held", 32'h1, 32'(gat_ready));
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    in_req      = 1'b0;
    in_alpha    = '0;
    in_wh_row   = '0;
    in_last     = 1'b0;
    rd_addr     = '0;
    lfsr_state  = 32'h6b8;
    cycle_count = 0;
    err_count   = 0;
    node_count  = 0;
    for (int k = 0; k < `GAT_NUM_FEATURE_OUT; k++) begin
      node_acc[k] = 0;
    end
    for (int a = 0; a < `GAT_FEAT_DEPTH; a++) begin
      model[a] = '0;
    end

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    test_reset_state();
    test_single_neighbor();
    test_multi_neighbor();
    test_back_pressure();
    test_run_completion();

    if (err_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+design
design/gat_pkg.sv
design/feature_aggregator.sv
design/feature_fifo.sv
design/feature_controller.sv
design/feature_bram.sv
design/gat_output_top.sv
tb/tb_gat_output.sv

// File: run_sim.sh
#!/bin/sh
# Build the GAT output stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  -f vlog.f \
  --top-module tb_gat_output \
  -o tb_gat_output
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_gat_output > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
fi

if grep -q "All checks passed" sim.log; then
  echo "Simulation PASSED"
  exit 0
else
  echo "Simulation FAILED"
  exit 1
fi
